/* source/alu_pkg.sv */
package alu_pkg;

	localparam int word_w = 32; // Datapath width
	localparam int num_lanes = 4; // Parallel execution lanes

	typedef logic [word_w-1:0] word_t;
	typedef logic [2*word_w-1:0] dword_t; // Full product
	typedef logic [4:0] alu_op_t;
	typedef logic [4:0] shamt_t;
	typedef logic [1:0] lane_idx_t;
	typedef logic [5:0] div_cnt_t; // Counts up to word_w

	// Operation encoding
	localparam alu_op_t op_and = 5'b00000;
	localparam alu_op_t op_or = 5'b00001;
	localparam alu_op_t op_xor = 5'b00010;
	localparam alu_op_t op_addu = 5'b00011;
	localparam alu_op_t op_subu = 5'b00100;
	localparam alu_op_t op_sltu = 5'b00101;
	localparam alu_op_t op_slt = 5'b00110;
	localparam alu_op_t op_multu = 5'b00111;
	localparam alu_op_t op_mult = 5'b01000;
	localparam alu_op_t op_sll = 5'b01001; // Amount in b[10:6]
	localparam alu_op_t op_sllv = 5'b01010; // Amount in b[4:0]
	localparam alu_op_t op_sra = 5'b01011;
	localparam alu_op_t op_srl = 5'b01100;
	localparam alu_op_t op_srav = 5'b01101;
	localparam alu_op_t op_srlv = 5'b01110;
	localparam alu_op_t op_div = 5'b01111;
	localparam alu_op_t op_divu = 5'b10000;
	localparam alu_op_t op_lui = 5'b10011;

	typedef enum logic [1:0] {
		lane_idle, // Waiting for an operation
		lane_div, // Iterating a divide
		lane_done // Result held for the collector
	} lane_state_e;

endpackage

/* source/alu_op_if.sv */
`timescale 1ns/100ps

interface alu_op_if;
	import alu_pkg::*;

	logic valid;
	logic ready;
	alu_op_t op;
	word_t a;
	word_t b;

	modport src (
		output valid, output op, output a, output b,
		input ready
	);
	modport dst (
		input valid, input op, input a, input b,
		output ready
	);

endinterface

/* source/alu_res_if.sv */
`timescale 1ns/100ps

interface alu_res_if;
	import alu_pkg::*;

	logic valid;
	logic ready;
	word_t lo; // Quotient or low product
	word_t hi; // Remainder or high product
	logic zero;

	modport src (
		output valid, output lo, output hi, output zero,
		input ready
	);
	modport dst (
		input valid, input lo, input hi, input zero,
		output ready
	);

endinterface

/* source/op_dispatcher.sv */
`timescale 1ns/100ps

module op_dispatcher (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input alu_pkg::alu_op_t in_op,
	input alu_pkg::word_t in_a,
	input alu_pkg::word_t in_b,
	alu_op_if.src lanes [alu_pkg::num_lanes]
);
	import alu_pkg::*;

	lane_idx_t issue_ptr; // Next lane to receive an operation
	logic [num_lanes-1:0] lane_ready;

	genvar g;
	generate
		for (g = 0; g < num_lanes; g++) begin : g_lane
			assign lanes[g].valid = in_valid && (issue_ptr == lane_idx_t'(g));
			assign lanes[g].op = in_op; // Payload goes to every lane
			assign lanes[g].a = in_a;
			assign lanes[g].b = in_b;
			assign lane_ready[g] = lanes[g].ready;
		end
	endgenerate

	assign in_ready = lane_ready[issue_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_ptr <= '0;
		end else if (in_valid && in_ready) begin
			if (issue_ptr == lane_idx_t'(num_lanes - 1)) begin
				issue_ptr <= '0;
			end else begin
				issue_ptr <= issue_ptr + 1'b1;
			end
		end
	end

endmodule

/* source/alu_lane.sv */
`timescale 1ns/100ps

module alu_lane (
	input logic clk,
	input logic rst_n,
	alu_op_if.dst op_in,
	alu_res_if.src res_out
);
	import alu_pkg::*;

	lane_state_e state;
	div_cnt_t div_cnt;
	logic accept;
	logic is_div;
	logic is_sdiv;

	word_t alu_lo; // Single-cycle result
	word_t alu_hi;
	dword_t prod_s;
	dword_t prod_u;
	shamt_t sh_fix;
	shamt_t sh_var;

	word_t lo_q;
	word_t hi_q;
	logic zero_q;

	word_t a_q; // Original dividend for special cases
	word_t dvs_q; // Divisor magnitude
	word_t quo_q; // Dividend shifts out, quotient shifts in
	word_t rem_q; // Partial remainder
	logic q_neg;
	logic r_neg;
	logic by_zero;
	logic ovf;
	logic [word_w:0] rem_shift;
	logic [word_w:0] rem_diff;
	word_t quo_fix;
	word_t rem_fix;

	assign accept = op_in.valid && op_in.ready;
	assign is_div = (op_in.op == op_div) || (op_in.op == op_divu);
	assign is_sdiv = (op_in.op == op_div);

	assign op_in.ready = (state == lane_idle);
	assign res_out.valid = (state == lane_done);
	assign res_out.lo = lo_q;
	assign res_out.hi = hi_q;
	assign res_out.zero = zero_q;

	always_comb begin
		prod_s = $signed(op_in.a) * $signed(op_in.b);
		prod_u = op_in.a * op_in.b;
		sh_fix = op_in.b[10:6];
		sh_var = op_in.b[4:0];
		alu_hi = '0;
		case (op_in.op)
			op_and: alu_lo = op_in.a & op_in.b;
			op_or: alu_lo = op_in.a | op_in.b;
			op_xor: alu_lo = op_in.a ^ op_in.b;
			op_addu: alu_lo = op_in.a + op_in.b;
			op_subu: alu_lo = op_in.a - op_in.b;
			op_sltu: alu_lo = word_t'(op_in.a < op_in.b);
			op_slt: alu_lo = word_t'($signed(op_in.a) < $signed(op_in.b));
			op_multu: {alu_hi, alu_lo} = prod_u;
			op_mult: {alu_hi, alu_lo} = prod_s;
			op_sll: alu_lo = op_in.a << sh_fix;
			op_sllv: alu_lo = op_in.a << sh_var;
			op_sra: alu_lo = $signed(op_in.a) >>> sh_fix; // Sign fill
			op_srl: alu_lo = op_in.a >> sh_fix;
			op_srav: alu_lo = $signed(op_in.a) >>> sh_var;
			op_srlv: alu_lo = op_in.a >> sh_var;
			op_lui: alu_lo = op_in.b << 16;
			default: alu_lo = '0; // Divides take the iterative path
		endcase
	end

	// One restoring step and the final sign correction
	always_comb begin
		rem_shift = {rem_q, quo_q[word_w-1]};
		rem_diff = rem_shift - {1'b0, dvs_q};
		if (by_zero) begin
			quo_fix = '1;
			rem_fix = a_q;
		end else if (ovf) begin
			quo_fix = a_q;
			rem_fix = '0;
		end else begin
			quo_fix = q_neg ? -quo_q : quo_q;
			rem_fix = r_neg ? -rem_q : rem_q; // Remainder follows dividend
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= lane_idle;
			div_cnt <= '0;
		end else begin
			case (state)
				lane_idle: begin
					if (accept) begin
						div_cnt <= '0;
						state <= is_div ? lane_div : lane_done;
					end
				end
				lane_div: begin
					div_cnt <= div_cnt + 1'b1;
					if (div_cnt == div_cnt_t'(word_w)) begin // Last cycle is the fixup
						state <= lane_done;
					end
				end
				lane_done: if (res_out.ready) state <= lane_idle;
				default: state <= lane_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_div) begin
			a_q <= op_in.a;
			quo_q <= (is_sdiv && op_in.a[word_w-1]) ? -op_in.a : op_in.a;
			dvs_q <= (is_sdiv && op_in.b[word_w-1]) ? -op_in.b : op_in.b;
			rem_q <= '0;
			q_neg <= is_sdiv && (op_in.a[word_w-1] ^ op_in.b[word_w-1]);
			r_neg <= is_sdiv && op_in.a[word_w-1];
			by_zero <= (op_in.b == '0);
			ovf <= is_sdiv && (op_in.a == {1'b1, {(word_w-1){1'b0}}}) && (op_in.b == '1);
		end else if (accept) begin
			lo_q <= alu_lo;
			hi_q <= alu_hi;
			zero_q <= (alu_lo == '0);
		end else if (state == lane_div) begin
			if (div_cnt == div_cnt_t'(word_w)) begin
				lo_q <= quo_fix;
				hi_q <= rem_fix;
				zero_q <= (quo_fix == '0);
			end else begin
				rem_q <= rem_diff[word_w] ? rem_shift[word_w-1:0] : rem_diff[word_w-1:0];
				quo_q <= {quo_q[word_w-2:0], ~rem_diff[word_w]}; // Restore on borrow
			end
		end
	end

endmodule

/* source/result_collector.sv */
`timescale 1ns/100ps

module result_collector (
	input logic clk,
	input logic rst_n,
	alu_res_if.dst lanes [alu_pkg::num_lanes],
	output logic out_valid,
	input logic out_ready,
	output alu_pkg::word_t out_lo,
	output alu_pkg::word_t out_hi,
	output logic out_zero
);
	import alu_pkg::*;

	lane_idx_t drain_ptr; // Follows the dispatcher's sequence
	logic [num_lanes-1:0] lane_valid;
	logic [num_lanes-1:0] lane_zero;
	word_t lane_lo [num_lanes];
	word_t lane_hi [num_lanes];

	genvar g;
	generate
		for (g = 0; g < num_lanes; g++) begin : g_lane
			assign lane_valid[g] = lanes[g].valid;
			assign lane_zero[g] = lanes[g].zero;
			assign lane_lo[g] = lanes[g].lo;
			assign lane_hi[g] = lanes[g].hi;
			assign lanes[g].ready = out_ready && (drain_ptr == lane_idx_t'(g));
		end
	endgenerate

	assign out_valid = lane_valid[drain_ptr];
	assign out_zero = lane_zero[drain_ptr];
	assign out_lo = lane_lo[drain_ptr];
	assign out_hi = lane_hi[drain_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			drain_ptr <= '0;
		end else if (out_valid && out_ready) begin
			if (drain_ptr == lane_idx_t'(num_lanes - 1)) begin
				drain_ptr <= '0;
			end else begin
				drain_ptr <= drain_ptr + 1'b1;
			end
		end
	end

endmodule

/* source/exec_cluster.sv */
`timescale 1ns/100ps

module exec_cluster (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input alu_pkg::alu_op_t in_op,
	input alu_pkg::word_t in_a,
	input alu_pkg::word_t in_b,
	output logic out_valid,
	input logic out_ready,
	output alu_pkg::word_t out_lo,
	output alu_pkg::word_t out_hi,
	output logic out_zero
);
	import alu_pkg::*;

	alu_op_if op_bus [num_lanes] (); // Dispatcher to lanes
	alu_res_if res_bus [num_lanes] (); // Lanes to collector

	op_dispatcher dispatch_i (
		.clk (clk),
		.rst_n (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_op (in_op),
		.in_a (in_a),
		.in_b (in_b),
		.lanes (op_bus)
	);

	genvar g;
	generate
		for (g = 0; g < num_lanes; g++) begin : g_lane
			alu_lane lane_i (
				.clk (clk),
				.rst_n (rst_n),
				.op_in (op_bus[g]),
				.res_out (res_bus[g])
			);
		end
	endgenerate

	result_collector collect_i (
		.clk (clk),
		.rst_n (rst_n),
		.lanes (res_bus),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_lo (out_lo),
		.out_hi (out_hi),
		.out_zero (out_zero)
	);

endmodule

/* include/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Expected lo, hi and zero for one operation
function automatic void alu_model(
	input alu_pkg::alu_op_t op,
	input alu_pkg::word_t a,
	input alu_pkg::word_t b,
	output alu_pkg::word_t lo,
	output alu_pkg::word_t hi,
	output logic zero
);
	alu_pkg::dword_t prod;
	alu_pkg::shamt_t sh_fix;
	alu_pkg::shamt_t sh_var;

	sh_fix = b[10:6];
	sh_var = b[4:0];
	lo = '0;
	hi = '0;
	case (op)
		alu_pkg::op_and: lo = a & b;
		alu_pkg::op_or: lo = a | b;
		alu_pkg::op_xor: lo = a ^ b;
		alu_pkg::op_addu: lo = a + b;
		alu_pkg::op_subu: lo = a - b;
		alu_pkg::op_sltu: lo = (a < b) ? 32'd1 : 32'd0;
		alu_pkg::op_slt: lo = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		alu_pkg::op_multu: begin
			prod = a * b;
			{hi, lo} = prod;
		end
		alu_pkg::op_mult: begin
			prod = $signed(a) * $signed(b); // Sign-extended to 64 bits
			{hi, lo} = prod;
		end
		alu_pkg::op_sll: lo = a << sh_fix;
		alu_pkg::op_sllv: lo = a << sh_var;
		alu_pkg::op_sra: lo = $signed(a) >>> sh_fix;
		alu_pkg::op_srl: lo = a >> sh_fix;
		alu_pkg::op_srav: lo = $signed(a) >>> sh_var;
		alu_pkg::op_srlv: lo = a >> sh_var;
		alu_pkg::op_div: begin
			if (b == '0) begin
				lo = '1;
				hi = a;
			end else if (a == 32'h8000_0000 && b == '1) begin
				lo = a; // Overflow keeps the dividend
				hi = '0;
			end else begin
				lo = $signed(a) / $signed(b); // Truncates toward zero
				hi = $signed(a) % $signed(b);
			end
		end
		alu_pkg::op_divu: begin
			if (b == '0) begin
				lo = '1;
				hi = a;
			end else begin
				lo = a / b;
				hi = a % b;
			end
		end
		alu_pkg::op_lui: lo = b << 16;
		default: lo = '0;
	endcase
	zero = (lo == '0);
endfunction

`endif

/* test/exec_cluster_tb.sv */
`timescale 1ns/100ps

module exec_cluster_tb;
	import alu_pkg::*;
	`include "alu_model.svh"

	localparam int seed_init = 32'hb68;
	localparam int num_tests = 400;
	localparam int timeout_cycles = 200;
	localparam int clk_period = 4;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	alu_op_t in_op;
	word_t in_a;
	word_t in_b;
	logic out_valid;
	logic out_ready;
	word_t out_lo;
	word_t out_hi;
	logic out_zero;

	int stim_seed;
	int ready_seed;
	int pass_count;
	int fail_count;
	logic test_bad; // Any compare failed in the current test
	string exp_name [$]; // Issue order
	word_t exp_lo [$];
	word_t exp_hi [$];
	logic exp_zero [$];

	exec_cluster dut_i (.*);

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic close_test(input string name);
		if (test_bad) begin
			fail_count++;
			$display("%s failed", name);
		end else begin
			pass_count++;
			$display("%s ok", name);
		end
		test_bad = 1'b0;
	endtask

	task automatic abort_run(input string what);
		$display("timeout waiting for %s", what);
		$display("passed %0d failed %0d", pass_count, fail_count);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	// Holds the operation until a lane takes it, then records the model result
	task automatic send_op(input string name, input alu_op_t op, input word_t a, input word_t b,
		output logic taken);
		int waited;
		word_t lo;
		word_t hi;
		logic zero;

		waited = 0;
		in_valid = 1'b1;
		in_op = op;
		in_a = a;
		in_b = b;
		while (!in_ready && waited < timeout_cycles) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!in_ready) begin
			taken = 1'b0;
		end else begin
			taken = 1'b1;
			alu_model(op, a, b, lo, hi, zero);
			exp_name.push_back(name);
			exp_lo.push_back(lo);
			exp_hi.push_back(hi);
			exp_zero.push_back(zero);
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Random back-pressure and result checking
	initial begin : monitor
		int idle;

		idle = 0;
		out_ready = 1'b0;
		while (idle <= timeout_cycles) begin
			@(posedge clk);
			#1;
			out_ready = ($random(ready_seed) % 4) != 0;
			if (out_valid && out_ready) begin
				idle = 0;
				if (exp_name.size() == 0) begin
					$display("result arrived with no operation outstanding");
					fail_count++;
				end else begin
					check_word({exp_name[0], " lo"}, exp_lo.pop_front(), out_lo);
					check_word({exp_name[0], " hi"}, exp_hi.pop_front(), out_hi);
					check_flag({exp_name[0], " zero"}, exp_zero.pop_front(), out_zero);
					close_test(exp_name.pop_front());
				end
			end else if (exp_name.size() != 0) begin
				idle++;
			end
		end
		abort_run("result");
	end

	initial begin : stimulus
		int n;
		int r;
		int waited;
		logic taken;
		alu_op_t op;
		word_t a;
		word_t b;

		stim_seed = seed_init;
		ready_seed = ~seed_init;
		pass_count = 0;
		fail_count = 0;
		test_bad = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = '0;
		in_a = '0;
		in_b = '0;
		taken = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_flag("reset out_valid", 1'b0, out_valid);
		check_flag("reset in_ready", 1'b1, in_ready);
		close_test("reset");

		for (n = 0; n < num_tests && taken; n++) begin
			r = {$random(stim_seed)} % 18;
			op = (r == 17) ? op_lui : alu_op_t'(r); // Codes 0 to 16 are all valid
			a = $random(stim_seed);
			b = $random(stim_seed);
			case ({$random(stim_seed)} % 8)
				0: b = '0; // Divide by zero
				1: begin
					a = 32'h8000_0000; // Signed overflow for div
					b = '1;
				end
				2: begin
					a = a % 32'd20;
					b = b % 32'd7;
				end
				3: b = b | 32'h0000_07df; // Both shift fields 31
				4: b = b & ~32'h0000_07df; // Both shift fields 0
				default: ;
			endcase
			send_op($sformatf("t%0d_op%0d", n, op), op, a, b, taken);
			if (n < num_tests / 2 && ({$random(stim_seed)} % 4) == 0) begin
				@(posedge clk); // Idle gap only in the first half
				#1;
			end
		end

		if (!taken) begin
			abort_run("in_ready");
		end else begin
			waited = 0;
			while (exp_name.size() != 0 && waited < timeout_cycles) begin
				@(posedge clk);
				#2;
				waited++;
			end
			if (exp_name.size() != 0) begin
				$display("results missing at end of run, %0d still expected", exp_name.size());
				fail_count++;
			end
			repeat (4) @(posedge clk);
			$display("passed %0d failed %0d", pass_count, fail_count);
			if (fail_count == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

/* flist.f */
+incdir+include
source/alu_pkg.sv
source/alu_op_if.sv
source/alu_res_if.sv
source/op_dispatcher.sv
source/alu_lane.sv
source/result_collector.sv
source/exec_cluster.sv
test/exec_cluster_tb.sv
